// File: verilog/aa_map_pkg.sv
// -----------------
// aa_map_pkg
// address map, register indices and word types of the
// access-aggregator control block
// -----------------
package aa_map_pkg;

    // local bus address, remote address field, data and strobes
    typedef logic [14:0] ls_addr_t;
    typedef logic [27:0] ss_addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    // word index inside a register window
    typedef logic [2:0]  mb_idx_t;

    // mailbox window, eight words
    localparam ls_addr_t mb_low  = 15'h2000;
    localparam ls_addr_t mb_high = 15'h201F;

    // control registers, enable then status
    localparam ls_addr_t aa_low  = 15'h2100;
    localparam ls_addr_t aa_high = 15'h2107;

    localparam mb_idx_t aa_en_idx   = 3'd0;
    localparam mb_idx_t aa_stat_idx = 3'd1;

    // returned for any address outside both windows
    localparam word_t unsupp_rdata = 32'hFFFF_FFFF;

    typedef enum logic [1:0] {
        region_mb,
        region_aa,
        region_other
    } region_t;

endpackage

// File: verilog/aa_req_pkg.sv
// -----------------
// aa_req_pkg
// request queue entries, user codes, dispatcher states and
// the register operation passed to the register file
// -----------------
package aa_req_pkg;

    // one local request, 52 bits, data and strobes zero on a read
    typedef struct packed {
        logic              write;
        aa_map_pkg::ls_addr_t addr;
        aa_map_pkg::word_t data;
        aa_map_pkg::strb_t strb;
    } ls_req_t;

    // one remote stream beat, 34 bits
    typedef struct packed {
        aa_map_pkg::word_t data;
        logic [1:0]        user;
    } ss_beat_t;

    // remote user codes
    localparam logic [1:0] user_wr = 2'b01;
    localparam logic [1:0] user_rd = 2'b10;

    localparam int queue_depth = 8;

    typedef enum logic [1:0] {
        st_wait,
        st_decide,
        st_move
    } disp_state_t;

    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic                  from_ss;
        aa_map_pkg::region_t   region;
        aa_map_pkg::mb_idx_t   idx;
        aa_map_pkg::word_t     data;
        aa_map_pkg::strb_t     strb;
    } reg_op_t;

endpackage

// File: verilog/aa_req_fifo.sv
// -----------------
// aa_req_fifo
// synchronous circular-buffer FIFO with a show-ahead head
// -----------------
module aa_req_fifo #(
    parameter int width = 8,
    parameter int depth = 8
) (
    input  logic             axi_aclk,
    input  logic             axi_aresetn,
    input  logic             push,
    input  logic             pop,
    input  logic [width-1:0] din,
    output logic [width-1:0] dout,
    output logic             not_empty,
    output logic             not_full
);

    typedef logic [$clog2(depth)-1:0]   ptr_t;
    typedef logic [$clog2(depth+1)-1:0] cnt_t;

    logic [width-1:0] mem [depth];
    ptr_t             wr_ptr;
    ptr_t             rd_ptr;
    cnt_t             count;

    assign dout      = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign not_full  = (count != cnt_t'(depth));

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + ptr_t'(1);
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + ptr_t'(1);
            end
            case ({push, pop})
                2'b10:   count <= count + cnt_t'(1);
                2'b01:   count <= count - cnt_t'(1);
                default: count <= count;
            endcase
        end
    end

    // queue entries
    always_ff @(posedge axi_aclk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    // producer and consumer sit in other modules
    a_no_overflow: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        push |-> not_full);
    a_no_underflow: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        pop |-> not_empty);

endmodule

// File: verilog/aa_ingress.sv
// -----------------
// aa_ingress
// packs local strobes and remote beats into their queues
// -----------------
module aa_ingress (
    input  logic                  axi_aclk,
    input  logic                  axi_aresetn,
    input  logic                  bk_ls_wstart,
    input  aa_map_pkg::ls_addr_t  bk_ls_waddr,
    input  aa_map_pkg::word_t     bk_ls_wdata,
    input  aa_map_pkg::strb_t     bk_ls_wstrb,
    input  logic                  bk_ls_rstart,
    input  aa_map_pkg::ls_addr_t  bk_ls_raddr,
    input  aa_map_pkg::word_t     bk_ss_data,
    input  logic [1:0]            bk_ss_user,
    input  logic                  bk_ss_valid,
    input  logic                  ls_pop,
    input  logic                  ss_pop,
    output logic                  bk_ss_ready,
    output aa_req_pkg::ls_req_t   ls_head,
    output logic                  ls_avail,
    output aa_req_pkg::ss_beat_t  ss_head,
    output logic                  ss_avail
);

    aa_req_pkg::ls_req_t  ls_in;
    aa_req_pkg::ss_beat_t ss_in;
    logic                 ls_push;
    logic                 ls_not_full;
    logic                 ss_push;
    logic                 ss_not_full;
    logic                 ss_live;

    // a start strobe on a full queue is lost
    assign ls_push = (bk_ls_wstart | bk_ls_rstart) & ls_not_full;

    always_comb begin
        ls_in = '0;
        if (bk_ls_wstart) begin
            ls_in.write = 1'b1;
            ls_in.addr  = bk_ls_waddr;
            ls_in.data  = bk_ls_wdata;
            ls_in.strb  = bk_ls_wstrb;
        end else begin
            ls_in.addr = bk_ls_raddr;
        end
    end

    // ready comes up one cycle after reset release
    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            ss_live <= 1'b0;
        end else begin
            ss_live <= 1'b1;
        end
    end

    assign bk_ss_ready = ss_live & ss_not_full;
    assign ss_push     = bk_ss_valid & bk_ss_ready;
    assign ss_in       = '{data: bk_ss_data, user: bk_ss_user};

    aa_req_fifo #(
        .width ($bits(aa_req_pkg::ls_req_t)),
        .depth (aa_req_pkg::queue_depth)
    ) u_ls_fifo (
        .axi_aclk, .axi_aresetn,
        .push (ls_push), .pop (ls_pop), .din (ls_in),
        .dout (ls_head), .not_empty (ls_avail), .not_full (ls_not_full)
    );

    aa_req_fifo #(
        .width ($bits(aa_req_pkg::ss_beat_t)),
        .depth (aa_req_pkg::queue_depth)
    ) u_ss_fifo (
        .axi_aclk, .axi_aresetn,
        .push (ss_push), .pop (ss_pop), .din (ss_in),
        .dout (ss_head), .not_empty (ss_avail), .not_full (ss_not_full)
    );

    // the config side uses one strobe at a time
    a_one_start: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        !(bk_ls_wstart && bk_ls_rstart));

endmodule

// File: verilog/aa_dispatch.sv
// -----------------
// aa_dispatch
// round-robin pick between the queues, window decode and
// remote beat pairing, one register operation at a time
// -----------------
module aa_dispatch (
    input  logic                  axi_aclk,
    input  logic                  axi_aresetn,
    input  aa_req_pkg::ls_req_t   ls_head,
    input  logic                  ls_avail,
    input  aa_req_pkg::ss_beat_t  ss_head,
    input  logic                  ss_avail,
    output logic                  ls_pop,
    output logic                  ss_pop,
    output aa_req_pkg::reg_op_t   reg_op
);

    aa_req_pkg::disp_state_t state;
    aa_req_pkg::disp_state_t state_nxt;
    logic                    sel_ss;
    logic                    last_ss;
    logic                    pick_ss;
    logic                    have_first;
    logic                    first_pop;
    aa_map_pkg::word_t       first_q;
    aa_map_pkg::ss_addr_t    ss_addr;
    aa_map_pkg::region_t     ls_region;
    aa_map_pkg::region_t     ss_region;
    aa_req_pkg::reg_op_t     op_q;
    aa_req_pkg::reg_op_t     op_nxt;

    function automatic aa_map_pkg::region_t decode_region(input aa_map_pkg::ss_addr_t a);
        if (a >= aa_map_pkg::ss_addr_t'(aa_map_pkg::mb_low) &&
            a <= aa_map_pkg::ss_addr_t'(aa_map_pkg::mb_high)) begin
            return aa_map_pkg::region_mb;
        end
        if (a >= aa_map_pkg::ss_addr_t'(aa_map_pkg::aa_low) &&
            a <= aa_map_pkg::ss_addr_t'(aa_map_pkg::aa_high)) begin
            return aa_map_pkg::region_aa;
        end
        return aa_map_pkg::region_other;
    endfunction

    // first remote beat carries {strb, addr}
    assign ss_addr   = first_q[27:0];
    assign ls_region = decode_region(aa_map_pkg::ss_addr_t'(ls_head.addr));
    assign ss_region = decode_region(ss_addr);

    // serve the side that was not served last
    assign pick_ss = ss_avail & (~ls_avail | ~last_ss);

    // --------------------
    always_comb begin
        state_nxt = state;
        op_nxt    = '0;
        first_pop = 1'b0;
        case (state)
            aa_req_pkg::st_wait: begin
                if (ls_avail || ss_avail) begin
                    state_nxt = aa_req_pkg::st_decide;
                end
            end
            aa_req_pkg::st_decide: begin
                if (!sel_ss) begin
                    // local writes outside both windows are dropped
                    op_nxt.valid  = !ls_head.write || (ls_region != aa_map_pkg::region_other);
                    op_nxt.write  = ls_head.write;
                    op_nxt.region = ls_region;
                    op_nxt.idx    = ls_head.addr[4:2];
                    op_nxt.data   = ls_head.data;
                    op_nxt.strb   = ls_head.strb;
                    state_nxt     = aa_req_pkg::st_move;
                end else if (ss_avail && have_first) begin
                    // second beat at the head, only the mailbox is writable remotely
                    op_nxt.valid   = (ss_region == aa_map_pkg::region_mb);
                    op_nxt.write   = 1'b1;
                    op_nxt.from_ss = 1'b1;
                    op_nxt.region  = ss_region;
                    op_nxt.idx     = ss_addr[4:2];
                    op_nxt.data    = ss_head.data;
                    op_nxt.strb    = first_q[31:28];
                    state_nxt      = aa_req_pkg::st_move;
                end else if (ss_avail) begin
                    case (ss_head.user)
                        aa_req_pkg::user_wr: first_pop = 1'b1;
                        // remote reads would need the lite master, consumed here
                        aa_req_pkg::user_rd: state_nxt = aa_req_pkg::st_move;
                        default:             state_nxt = aa_req_pkg::st_move;
                    endcase
                end
            end
            aa_req_pkg::st_move: state_nxt = aa_req_pkg::st_wait;
            default:             state_nxt = aa_req_pkg::st_wait;
        endcase
    end

    assign ls_pop = (state == aa_req_pkg::st_move) && !sel_ss;
    assign ss_pop = ((state == aa_req_pkg::st_move) && sel_ss) || first_pop;

    // op is visible for the single move cycle
    always_comb begin
        reg_op       = op_q;
        reg_op.valid = op_q.valid && (state == aa_req_pkg::st_move);
    end

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            state      <= aa_req_pkg::st_wait;
            sel_ss     <= 1'b0;
            last_ss    <= 1'b1;
            have_first <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == aa_req_pkg::st_wait) begin
                sel_ss <= pick_ss;
            end
            if (first_pop) begin
                have_first <= 1'b1;
            end
            if (state == aa_req_pkg::st_move) begin
                last_ss    <= sel_ss;
                have_first <= 1'b0;
            end
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (first_pop) begin
            first_q <= ss_head.data;
        end
        if (state == aa_req_pkg::st_decide && state_nxt == aa_req_pkg::st_move) begin
            op_q <= op_nxt;
        end
    end

endmodule

// File: verilog/aa_regfile.sv
// -----------------
// aa_regfile
// mailbox words, interrupt enable and status, local read
// response and the remote-write interrupt pulse
// -----------------
module aa_regfile (
    input  logic                axi_aclk,
    input  logic                axi_aresetn,
    input  aa_req_pkg::reg_op_t reg_op,
    output aa_map_pkg::word_t   bk_ls_rdata,
    output logic                bk_ls_rdone,
    output logic                axi_interrupt
);

    aa_map_pkg::word_t mb_regs [8];
    logic              int_en;
    logic              int_stat;
    logic              wr_op;
    logic              rd_op;
    aa_map_pkg::word_t rd_word;

    assign wr_op = reg_op.valid && reg_op.write;
    assign rd_op = reg_op.valid && !reg_op.write && !reg_op.from_ss;

    // control words hold a single bit each, the rest reads zero
    always_comb begin
        rd_word = '0;
        case (reg_op.region)
            aa_map_pkg::region_mb: rd_word = mb_regs[reg_op.idx];
            aa_map_pkg::region_aa: begin
                if (reg_op.idx == aa_map_pkg::aa_en_idx) begin
                    rd_word[0] = int_en;
                end else if (reg_op.idx == aa_map_pkg::aa_stat_idx) begin
                    rd_word[0] = int_stat;
                end
            end
            default: rd_word = aa_map_pkg::unsupp_rdata;
        endcase
    end

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            for (int i = 0; i < 8; i++) begin
                mb_regs[i] <= '0;
            end
            int_en        <= 1'b0;
            int_stat      <= 1'b0;
            bk_ls_rdone   <= 1'b0;
            axi_interrupt <= 1'b0;
        end else begin
            bk_ls_rdone   <= rd_op;
            axi_interrupt <= 1'b0;
            if (wr_op && reg_op.region == aa_map_pkg::region_mb) begin
                for (int b = 0; b < 4; b++) begin
                    if (reg_op.strb[b]) begin
                        mb_regs[reg_op.idx][8*b +: 8] <= reg_op.data[8*b +: 8];
                    end
                end
                // remote mailbox write raises the interrupt
                if (reg_op.from_ss && int_en) begin
                    axi_interrupt <= 1'b1;
                    int_stat      <= 1'b1;
                end
            end
            if (wr_op && reg_op.region == aa_map_pkg::region_aa && reg_op.strb[0]) begin
                if (reg_op.idx == aa_map_pkg::aa_en_idx) begin
                    int_en <= reg_op.data[0];
                end
                // status is write-one-to-clear
                if (reg_op.idx == aa_map_pkg::aa_stat_idx && reg_op.data[0]) begin
                    int_stat <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (rd_op) begin
            bk_ls_rdata <= rd_word;
        end
    end

    // dispatcher serves one item at a time, so done is a single pulse
    a_rdone_pulse: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
        bk_ls_rdone |=> !bk_ls_rdone);

endmodule

// File: verilog/aa_ctrl_top.sv
// -----------------
// aa_ctrl_top
// access-aggregator control block, queues, dispatcher and registers
// -----------------
module aa_ctrl_top (
    input  logic                 axi_aclk,
    input  logic                 axi_aresetn,
    output logic                 axi_interrupt,
    // local lite side
    input  logic                 bk_ls_wstart,
    input  aa_map_pkg::ls_addr_t bk_ls_waddr,
    input  aa_map_pkg::word_t    bk_ls_wdata,
    input  aa_map_pkg::strb_t    bk_ls_wstrb,
    input  logic                 bk_ls_rstart,
    input  aa_map_pkg::ls_addr_t bk_ls_raddr,
    output aa_map_pkg::word_t    bk_ls_rdata,
    output logic                 bk_ls_rdone,
    // remote stream side
    input  aa_map_pkg::word_t    bk_ss_data,
    input  logic [1:0]           bk_ss_user,
    input  logic                 bk_ss_valid,
    output logic                 bk_ss_ready
);

    aa_req_pkg::ls_req_t  ls_head;
    aa_req_pkg::ss_beat_t ss_head;
    logic                 ls_avail;
    logic                 ss_avail;
    logic                 ls_pop;
    logic                 ss_pop;
    aa_req_pkg::reg_op_t  reg_op;

    aa_ingress u_ingress (.*);

    aa_dispatch u_dispatch (.*);

    aa_regfile u_regfile (.*);

endmodule

// File: test/aa_ctrl_model.svh
// --------------------
// aa_ctrl_model
// reference model of the mailbox and interrupt registers,
// with the expected read value of every local address
// --------------------
`ifndef AA_CTRL_MODEL_SVH
`define AA_CTRL_MODEL_SVH

logic [31:0] mdl_mb [8];
logic        mdl_en;
logic        mdl_stat;
int          mdl_int_count;

// 0 mailbox, 1 control words, 2 anything else
function automatic int addr_kind(input logic [14:0] addr);
    if (addr >= 15'h2000 && addr <= 15'h201F) begin
        return 0;
    end
    if (addr >= 15'h2100 && addr <= 15'h2107) begin
        return 1;
    end
    return 2;
endfunction

function automatic logic ss_in_mailbox(input logic [27:0] addr);
    return (addr >= 28'h000_2000) && (addr <= 28'h000_201F);
endfunction

function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                            input logic [31:0] new_w,
                                            input logic [3:0]  strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
        end
    end
    return res;
endfunction

function automatic logic [31:0] expected_read(input logic [14:0] addr);
    case (addr_kind(addr))
        0:       return mdl_mb[addr[4:2]];
        1:       return addr[2] ? {31'b0, mdl_stat} : {31'b0, mdl_en};
        default: return 32'hFFFF_FFFF;
    endcase
endfunction

task automatic model_ls_write(input logic [14:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
    if (addr_kind(addr) == 0) begin
        mdl_mb[addr[4:2]] = merge_bytes(mdl_mb[addr[4:2]], data, strb);
    end else if (addr_kind(addr) == 1 && strb[0]) begin
        // enable is word 0, status word 1 clears on a one
        if (!addr[2]) begin
            mdl_en = data[0];
        end else if (data[0]) begin
            mdl_stat = 1'b0;
        end
    end
endtask

task automatic model_ss_write(input logic [27:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
    if (ss_in_mailbox(addr)) begin
        mdl_mb[addr[4:2]] = merge_bytes(mdl_mb[addr[4:2]], data, strb);
        if (mdl_en) begin
            mdl_stat      = 1'b1;
            mdl_int_count = mdl_int_count + 1;
        end
    end
endtask

`endif

// File: test/aa_ctrl_tb.sv
// --------------------
// aa_ctrl_tb
// random local and remote traffic checked against a register model
// --------------------
module aa_ctrl_tb;

    localparam int num_mb_tests = 24;
    localparam int num_other    = 16;
    localparam int num_mix      = 60;
    // transactions in the whole run, each takes well under 30 cycles
    localparam int test_items   = 2 * num_mb_tests + 3 * num_other + 2 * num_mix + 40;

    logic        axi_aclk;
    logic        axi_aresetn;
    logic        axi_interrupt;
    logic        bk_ls_wstart;
    logic [14:0] bk_ls_waddr;
    logic [31:0] bk_ls_wdata;
    logic [3:0]  bk_ls_wstrb;
    logic        bk_ls_rstart;
    logic [14:0] bk_ls_raddr;
    logic [31:0] bk_ls_rdata;
    logic        bk_ls_rdone;
    logic [31:0] bk_ss_data;
    logic [1:0]  bk_ss_user;
    logic        bk_ss_valid;
    logic        bk_ss_ready;

    integer seed;
    int     int_seen = 0;

    `include "aa_ctrl_model.svh"

    aa_ctrl_top u_dut (.*);

    initial axi_aclk = 1'b0;
    always #4 axi_aclk = ~axi_aclk;

    // interrupt pulses counted where they are stable
    always @(negedge axi_aclk) begin
        if (axi_aresetn && axi_interrupt) begin
            int_seen <= int_seen + 1;
        end
    end

    // --------------------
    task automatic report_failure(input string what);
        $display("ERROR: %s", what);
        $display("Verification failed");
        $fatal(1, "run stopped after an error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] act,
                                 input logic [31:0] exp);
        if (act !== exp) begin
            $display("[FAIL] %s: actual 0x%08h expected 0x%08h", name, act, exp);
            $display("Verification failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    // --------------------
    task automatic ls_write(input logic [14:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
        @(posedge axi_aclk);
        bk_ls_wstart <= 1'b1;
        bk_ls_waddr  <= addr;
        bk_ls_wdata  <= data;
        bk_ls_wstrb  <= strb;
        @(posedge axi_aclk);
        bk_ls_wstart <= 1'b0;
        model_ls_write(addr, data, strb);
        repeat (8) @(posedge axi_aclk);
    endtask

    task automatic check_read(input logic [14:0] addr);
        int waited;
        waited = 0;
        @(posedge axi_aclk);
        bk_ls_rstart <= 1'b1;
        bk_ls_raddr  <= addr;
        @(posedge axi_aclk);
        bk_ls_rstart <= 1'b0;
        @(negedge axi_aclk);
        while (!bk_ls_rdone) begin
            if (waited == 20) begin
                report_failure($sformatf("no bk_ls_rdone for read of 0x%04h", addr));
            end
            waited++;
            @(negedge axi_aclk);
        end
        compare_value($sformatf("bk_ls_rdata at 0x%04h", addr), bk_ls_rdata,
                      expected_read(addr));
    endtask

    // called just after a rising edge, returns at the edge that took the beat
    task automatic ss_beat(input logic [31:0] data, input logic [1:0] user);
        int waited;
        waited = 0;
        bk_ss_valid <= 1'b1;
        bk_ss_data  <= data;
        bk_ss_user  <= user;
        @(negedge axi_aclk);
        while (!bk_ss_ready) begin
            if (waited == 20) begin
                report_failure("remote beat was never accepted");
            end
            waited++;
            @(negedge axi_aclk);
        end
        @(posedge axi_aclk);
    endtask

    task automatic ss_write(input logic [27:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
        int          waited;
        logic [31:0] r;
        waited = 0;
        r      = rnd();
        @(posedge axi_aclk);
        ss_beat({strb, addr}, 2'b01);
        ss_beat(data, r[1:0]);
        bk_ss_valid <= 1'b0;
        model_ss_write(addr, data, strb);
        while (int_seen != mdl_int_count && waited < 6) begin
            @(posedge axi_aclk);
            waited++;
        end
        if (int_seen < mdl_int_count) begin
            report_failure("interrupt missing within 6 cycles of a remote mailbox write");
        end
        repeat (8 - waited) @(posedge axi_aclk);
        if (int_seen != mdl_int_count) begin
            report_failure("unexpected extra interrupt pulse");
        end
    endtask

    // single remote item that the block consumes and ignores
    task automatic ss_ignored(input logic [31:0] data, input logic [1:0] user);
        @(posedge axi_aclk);
        ss_beat(data, user);
        bk_ss_valid <= 1'b0;
        repeat (6) @(posedge axi_aclk);
    endtask

    task automatic pick_other_addr(output logic [14:0] addr);
        logic [31:0] r;
        do begin
            r = rnd();
            // half inside the decoded page, half anywhere
            addr = r[31] ? {3'b010, r[11:0]} : r[14:0];
        end while (addr_kind(addr) != 2);
    endtask

    task automatic check_all_regs();
        for (int i = 0; i < 8; i++) begin
            check_read(15'h2000 + 15'(4 * i));
        end
        check_read(15'h2100);
        check_read(15'h2104);
    endtask

    function automatic logic [14:0] rand_mb_addr();
        logic [31:0] r;
        r = rnd();
        return {10'h100, r[4:0]};
    endfunction

    // --------------------
    initial begin : watchdog
        repeat (test_items * 30) @(posedge axi_aclk);
        report_failure("watchdog timeout, the run did not finish in time");
    end

    initial begin : main
        logic [31:0] r;
        logic [14:0] a;
        logic [27:0] sa;
        seed         = 89;
        axi_aresetn  = 1'b0;
        bk_ls_wstart = 1'b0;
        bk_ls_waddr  = '0;
        bk_ls_wdata  = '0;
        bk_ls_wstrb  = '0;
        bk_ls_rstart = 1'b0;
        bk_ls_raddr  = '0;
        bk_ss_data   = '0;
        bk_ss_user   = '0;
        bk_ss_valid  = 1'b0;
        for (int i = 0; i < 8; i++) begin
            mdl_mb[i] = '0;
        end
        mdl_en        = 1'b0;
        mdl_stat      = 1'b0;
        mdl_int_count = 0;

        repeat (2) @(posedge axi_aclk);
        compare_value("bk_ss_ready in reset", {31'b0, bk_ss_ready}, 32'h0);
        compare_value("bk_ls_rdone in reset", {31'b0, bk_ls_rdone}, 32'h0);
        compare_value("axi_interrupt in reset", {31'b0, axi_interrupt}, 32'h0);
        axi_aresetn <= 1'b1;
        repeat (2) @(posedge axi_aclk);
        compare_value("bk_ss_ready after reset", {31'b0, bk_ss_ready}, 32'h1);

        // strobe-merged mailbox writes
        for (int i = 0; i < num_mb_tests; i++) begin
            a = rand_mb_addr();
            r = rnd();
            ls_write(a, rnd(), r[3:0]);
            check_read(a);
        end

        // unmapped addresses read all ones and take no writes
        for (int i = 0; i < num_other; i++) begin
            pick_other_addr(a);
            check_read(a);
            r = rnd();
            ls_write(a, rnd(), r[3:0]);
            check_read(a);
        end
        check_all_regs();

        // enabled remote write raises one interrupt and sets status
        ls_write(15'h2100, 32'h1, 4'hF);
        check_read(15'h2100);
        a = rand_mb_addr();
        ss_write({13'b0, a}, rnd(), 4'hF);
        check_read(a);
        check_read(15'h2104);

        // status clears on a one, then a disabled remote write stays quiet
        ls_write(15'h2104, 32'h1, 4'hF);
        check_read(15'h2104);
        ls_write(15'h2100, 32'h0, 4'hF);
        check_read(15'h2100);
        a = rand_mb_addr();
        ss_write({13'b0, a}, rnd(), 4'hF);
        check_read(a);
        check_read(15'h2104);

        // mixed traffic
        for (int i = 0; i < num_mix; i++) begin
            r = rnd();
            case (r[2:0])
                3'd0, 3'd1: ls_write(rand_mb_addr(), rnd(), r[7:4]);
                3'd2: begin
                    pick_other_addr(a);
                    ls_write(a, rnd(), r[7:4]);
                end
                3'd3, 3'd4: ss_write({13'b0, rand_mb_addr()}, rnd(), r[7:4]);
                3'd5: ss_ignored(rnd(), {1'b1, r[10]});
                3'd6: begin
                    do begin
                        sa = 28'(rnd()) & 28'h000_3FFF;
                    end while (ss_in_mailbox(sa));
                    ss_write(sa, rnd(), r[7:4]);
                end
                default: check_read(rand_mb_addr());
            endcase
        end
        check_all_regs();
        compare_value("axi_interrupt pulse count", int_seen, mdl_int_count);

        $display("Verification passed");
        $finish;
    end

endmodule

// File: aa_ctrl.f
+incdir+test
verilog/aa_map_pkg.sv
verilog/aa_req_pkg.sv
verilog/aa_req_fifo.sv
verilog/aa_ingress.sv
verilog/aa_dispatch.sv
verilog/aa_regfile.sv
verilog/aa_ctrl_top.sv
test/aa_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it
# the exit status follows the simulation

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f aa_ctrl.f --top-module aa_ctrl_tb -o aa_ctrl_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/aa_ctrl_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

exit 0
